// File: run_sim.sh
#!/bin/sh
# build and run the triangle engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tri_engine_tb -f src.f -o tri_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/tri_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0

// File: src.f
src/tri_pkg.sv
src/coef_lut.sv
src/sample_mem.sv
src/tri_index_counter.sv
src/tri_ctrl_fsm.sv
src/row_accumulator.sv
src/tri_engine_top.sv
tb/tb_clock_gen.sv
tb/tri_engine_chk.sv
tb/tri_engine_tb.sv

// File: src/coef_lut.sv
`timescale 1ns/1ps

// u table: 4*(row-col+1) for col <= row, else 0
module lut_u_module #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  enable,
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0] q
);

    localparam int HW = ADDR_WIDTH / 2;

    logic [HW-1:0] r;
    logic [HW-1:0] c;
    logic [HW:0]   diff; // row - col + 1, up to 2**HW

    assign r    = addr[ADDR_WIDTH-1:HW];
    assign c    = addr[HW-1:0];
    assign diff = {1'b0, r} - {1'b0, c} + 1'b1;

    always_comb begin
        if (enable && (c <= r)) begin
            q = DATA_WIDTH'({diff, 2'b00}); // times 4
        end else begin
            q = '0;
        end
    end

endmodule

// v table: 4*(row-col) for col < row, else 0
module lut_v_module #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 8
) (
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0] q
);

    localparam int HW = ADDR_WIDTH / 2;

    logic [HW-1:0] r;
    logic [HW-1:0] c;

    assign r = addr[ADDR_WIDTH-1:HW];
    assign c = addr[HW-1:0];
    assign q = (c < r) ? DATA_WIDTH'({r - c, 2'b00}) : '0; // upper half and diagonal are 0

endmodule

// File: src/row_accumulator.sv
`timescale 1ns/1ps

module row_accumulator (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             run,
    input  logic             row_end,
    input  tri_pkg::idx_t    row,
    input  tri_pkg::idx_t    col,
    input  tri_pkg::sample_t x,
    input  tri_pkg::coef_t   cu,
    input  tri_pkg::coef_t   cv,
    output logic             out_valid,
    output tri_pkg::idx_t    out_row,
    output tri_pkg::acc_t    y_u,
    output tri_pkg::acc_t    y_v
);

    tri_pkg::acc_t acc_u;
    tri_pkg::acc_t acc_v;
    tri_pkg::acc_t sum_u;
    tri_pkg::acc_t sum_v;
    logic          first;

    assign first = (col == '0); // fresh sum at column 0

    assign sum_u = (first ? '0 : acc_u) + tri_pkg::acc_t'(cu) * tri_pkg::acc_t'(x);
    assign sum_v = (first ? '0 : acc_v) + tri_pkg::acc_t'(cv) * tri_pkg::acc_t'(x);

    always_ff @(posedge clk) begin
        if (run) begin
            acc_u <= sum_u;
            acc_v <= sum_v;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_row   <= '0;
            y_u       <= '0;
            y_v       <= '0;
        end else begin
            out_valid <= run && row_end;
            if (run && row_end) begin
                out_row <= row;
                y_u     <= sum_u; // includes the diagonal term
                y_v     <= sum_v;
            end
        end
    end

endmodule

// File: src/sample_mem.sv
`timescale 1ns/1ps

module sample_mem (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              we,
    input  tri_pkg::idx_t     wr_idx,
    input  tri_pkg::sample_t  wr_data,
    input  tri_pkg::idx_t     rd_idx,
    output tri_pkg::sample_t  rd_data
);

    tri_pkg::sample_t mem [tri_pkg::tri_n];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < tri_pkg::tri_n; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    assign rd_data = mem[rd_idx]; // combinational read at current column

endmodule

// File: src/tri_ctrl_fsm.sv
`timescale 1ns/1ps

module tri_ctrl_fsm (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    input  logic wr,
    input  logic tri_end,
    output logic mem_we,
    output logic cnt_clr,
    output logic run,
    output logic busy,
    output logic done
);

    tri_pkg::ctrl_state_t state;
    tri_pkg::ctrl_state_t state_nxt;
    logic                 idle_ok;

    assign run     = (state == tri_pkg::st_run);
    assign busy    = run || done;  // held through the last result cycle
    assign idle_ok = !busy;
    assign cnt_clr = start && idle_ok;
    assign mem_we  = wr && idle_ok; // no writes while running

    always_comb begin
        state_nxt = state;
        case (state)
            tri_pkg::st_idle: begin
                if (cnt_clr) begin
                    state_nxt = tri_pkg::st_run;
                end
            end
            tri_pkg::st_run: begin
                if (tri_end) begin
                    state_nxt = tri_pkg::st_idle;
                end
            end
            default: state_nxt = tri_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= tri_pkg::st_idle;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= run && tri_end; // lines up with row 15 out_valid
        end
    end

endmodule

// File: src/tri_engine_top.sv
`timescale 1ns/1ps

module tri_engine_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr,
    input  tri_pkg::idx_t    wr_idx,
    input  tri_pkg::sample_t wr_data,
    input  logic             start,
    output logic             busy,
    output logic             out_valid,
    output tri_pkg::idx_t    out_row,
    output tri_pkg::acc_t    y_u,
    output tri_pkg::acc_t    y_v,
    output logic             done
);

    localparam int DATA_WIDTH = $bits(tri_pkg::coef_t);
    localparam int ADDR_WIDTH = $bits(tri_pkg::addr_t);

    logic             mem_we;
    logic             cnt_clr;
    logic             run;
    logic             row_end;
    logic             tri_end;
    tri_pkg::idx_t    row;
    tri_pkg::idx_t    col;
    tri_pkg::addr_t   addr;
    tri_pkg::sample_t x;
    tri_pkg::coef_t   cu;
    tri_pkg::coef_t   cv;

    assign addr = {row, col}; // row in high nibble

    tri_ctrl_fsm u_fsm (
        .clk(clk), .arst_n(arst_n), .start(start), .wr(wr), .tri_end(tri_end),
        .mem_we(mem_we), .cnt_clr(cnt_clr), .run(run), .busy(busy), .done(done)
    );

    tri_index_counter u_cnt (
        .clk(clk), .arst_n(arst_n), .cnt_clr(cnt_clr), .run(run),
        .row(row), .col(col), .row_end(row_end), .tri_end(tri_end)
    );

    sample_mem u_mem (
        .clk(clk), .arst_n(arst_n), .we(mem_we), .wr_idx(wr_idx), .wr_data(wr_data),
        .rd_idx(col), .rd_data(x)
    );

    lut_u_module #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_lut_u (
        .enable(run), .addr(addr), .q(cu)
    );

    lut_v_module #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_lut_v (
        .addr(addr), .q(cv)
    );

    row_accumulator u_acc (
        .clk(clk), .arst_n(arst_n), .run(run), .row_end(row_end), .row(row), .col(col),
        .x(x), .cu(cu), .cv(cv),
        .out_valid(out_valid), .out_row(out_row), .y_u(y_u), .y_v(y_v)
    );

endmodule

// File: src/tri_index_counter.sv
`timescale 1ns/1ps

module tri_index_counter (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          cnt_clr,
    input  logic          run,
    output tri_pkg::idx_t row,
    output tri_pkg::idx_t col,
    output logic          row_end,
    output logic          tri_end
);

    localparam tri_pkg::idx_t LAST = tri_pkg::idx_t'(tri_pkg::tri_n - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row <= '0;
            col <= '0;
        end else if (cnt_clr) begin
            row <= '0;
            col <= '0;
        end else if (run) begin
            if (row_end) begin
                row <= row + 1'b1; // wraps to 0 after last row
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // diagonal reached
    assign row_end = (col == row);
    assign tri_end = (row == LAST) && (col == LAST);

endmodule

// File: src/tri_pkg.sv
package tri_pkg;

    localparam int tri_n = 16; // rows and samples

    typedef logic [3:0]  idx_t;    // row or column index
    typedef logic [7:0]  addr_t;   // {row, col}
    typedef logic [7:0]  sample_t; // unsigned sample
    typedef logic [15:0] coef_t;   // table coefficient
    typedef logic [31:0] acc_t;    // row sum, max 64*255*16

    typedef enum logic {
        st_idle,
        st_run
    } ctrl_state_t;

endpackage

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: tb/tri_engine_chk.sv
`timescale 1ns/1ps

module tri_engine_chk (
    input logic          clk,
    input logic          arst_n,
    input logic          busy,
    input logic          out_valid,
    input logic          done,
    input tri_pkg::idx_t out_row,
    input tri_pkg::acc_t y_u,
    input tri_pkg::acc_t y_v
);

    // done only with the last row result
    a_done_valid: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> out_valid && (out_row == 4'hf))
        else $error("done without the row 15 result");

    a_valid_busy: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> busy)
        else $error("out_valid while not busy");

    a_idle_after_done: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !busy)
        else $error("busy still high after done");

    // result registers hold while idle
    a_quiet_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !busy |=> $stable(out_row) && $stable(y_u) && $stable(y_v))
        else $error("row outputs changed while idle");

endmodule

bind tri_engine_top tri_engine_chk u_chk (
    .clk(clk), .arst_n(arst_n), .busy(busy), .out_valid(out_valid), .done(done),
    .out_row(out_row), .y_u(y_u), .y_v(y_v)
);

// File: tb/tri_engine_tb.sv
`timescale 1ns/1ps

module tri_engine_tb;

    localparam int clk_period = 20;
    localparam int n_file     = 7;
    localparam int n_words    = 18;                  // 16 samples, y_u(15), y_v(15)
    localparam int n_lcg      = 4;
    localparam int n_runs     = n_file + n_lcg + 2; // plus rerun and one-sample change
    localparam int rst_cyc    = 8;
    localparam int run_limit  = 200;

    logic             clk;
    logic             arst_n;
    logic             wr;
    tri_pkg::idx_t    wr_idx;
    tri_pkg::sample_t wr_data;
    logic             start;
    logic             busy;
    logic             out_valid;
    tri_pkg::idx_t    out_row;
    tri_pkg::acc_t    y_u;
    tri_pkg::acc_t    y_v;
    logic             done;

    logic [31:0]      tdata [n_file * n_words];
    tri_pkg::sample_t shadow [16]; // what the sample store should hold
    tri_pkg::acc_t    exp_u [16];
    tri_pkg::acc_t    exp_v [16];
    tri_pkg::acc_t    got_u [16];
    tri_pkg::acc_t    got_v [16];
    tri_pkg::acc_t    prev_u [16];
    tri_pkg::acc_t    prev_v [16];
    int               cyc = 0;
    int               val_errs = 0;
    int               other_errs = 0;
    logic [31:0]      lcg_state;

    tb_clock_gen #(.PERIOD_NS(clk_period)) u_clk (.clk(clk));

    tri_engine_top dut (
        .clk(clk), .arst_n(arst_n), .wr(wr), .wr_idx(wr_idx), .wr_data(wr_data),
        .start(start), .busy(busy), .out_valid(out_valid), .out_row(out_row),
        .y_u(y_u), .y_v(y_v), .done(done)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%08h exp 0x%08h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            $display("%s", what);
            other_errs++;
        end
    endtask

    // row sums straight from the u and v coefficient rules
    task automatic model_rows();
        for (int i = 0; i < 16; i++) begin
            exp_u[i] = '0;
            exp_v[i] = '0;
            for (int j = 0; j <= i; j++) begin
                exp_u[i] += tri_pkg::acc_t'(4 * (i - j + 1)) * tri_pkg::acc_t'(shadow[j]);
                if (j < i) begin
                    exp_v[i] += tri_pkg::acc_t'(4 * (i - j)) * tri_pkg::acc_t'(shadow[j]);
                end
            end
        end
    endtask

    task automatic write_sample(input int idx, input tri_pkg::sample_t data);
        @(negedge clk);
        wr      = 1'b1;
        wr_idx  = tri_pkg::idx_t'(idx);
        wr_data = data;
        shadow[idx] = data;
    endtask

    task automatic end_writes();
        @(negedge clk);
        wr = 1'b0;
    endtask

    // one start, then collect the 16 row results until done
    task automatic run_engine(input bit disturb);
        int          t0;
        int          n;
        int          rows;
        bit          fin;
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            got_u[i] = 'x;
            got_v[i] = 'x;
        end
        @(negedge clk);
        start = 1'b1;
        t0    = cyc + 1; // edge that samples start
        @(negedge clk);
        start = 1'b0;
        check_true(busy, "busy did not rise after start");
        rows = 0;
        fin  = 1'b0;
        n    = 0;
        while (!fin && n < run_limit) begin
            @(negedge clk);
            n++;
            wr    = 1'b0;
            start = 1'b0;
            if (out_valid && rows < 16) begin
                check_val($sformatf("out_row"), 32'(out_row), 32'(rows));
                check_true(cyc - t0 == (rows + 1) * (rows + 2) / 2,
                    $sformatf("row %0d came %0d cycles after start", rows, cyc - t0));
                check_val($sformatf("y_u[%0d]", rows), y_u, exp_u[rows]);
                check_val($sformatf("y_v[%0d]", rows), y_v, exp_v[rows]);
                got_u[rows] = y_u;
                got_v[rows] = y_v;
                rows++;
            end else if (out_valid) begin
                check_true(1'b0, "more than 16 row results in one run");
            end
            if (done) begin
                fin = 1'b1;
                check_true(cyc - t0 == 136,
                    $sformatf("done came %0d cycles after start instead of 136", cyc - t0));
            end else if (disturb && (n % 9 == 4)) begin
                r       = lcg_next();
                wr      = 1'b1;   // must be ignored while busy
                wr_idx  = r[19:16];
                wr_data = r[27:20];
                start   = (n % 18 == 4);
            end
        end
        check_true(fin, "no done pulse within the run limit");
        check_true(rows == 16, $sformatf("%0d row results instead of 16", rows));
        @(negedge clk);
        check_true(!busy && !out_valid && !done, "engine did not go idle after done");
    endtask

    initial begin
        logic [31:0] r;
        arst_n    = 1'b0;
        wr        = 1'b0;
        wr_idx    = '0;
        wr_data   = '0;
        start     = 1'b0;
        lcg_state = 32'd52;
        $readmemh("tb/tri_testdata.hex", tdata);
        repeat (rst_cyc) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_true(!busy && !out_valid && !done, "control outputs not low after reset");
        check_val("y_u", y_u, 32'h0);
        check_val("y_v", y_v, 32'h0);
        check_val("out_row", 32'(out_row), 32'h0);

        for (int c = 0; c < n_file; c++) begin
            for (int k = 0; k < 16; k++) begin
                write_sample(k, tdata[c * n_words + k][7:0]);
            end
            end_writes();
            model_rows();
            run_engine(1'b0);
            check_val($sformatf("file %0d y_u[15]", c), got_u[15], tdata[c * n_words + 16]);
            check_val($sformatf("file %0d y_v[15]", c), got_v[15], tdata[c * n_words + 17]);
        end

        for (int c = 0; c < n_lcg; c++) begin
            for (int k = 0; k < 16; k++) begin
                r = lcg_next();
                write_sample(k, r[23:16]);
            end
            end_writes();
            model_rows();
            run_engine(c == 2);
            if (c == 2) begin
                run_engine(1'b0); // stray writes must not have landed
            end
        end

        // change sample 6 only, rows 0 to 5 keep their sums
        prev_u = exp_u;
        prev_v = exp_v;
        write_sample(6, shadow[6] ^ 8'ha5);
        end_writes();
        model_rows();
        run_engine(1'b0);
        for (int i = 0; i < 6; i++) begin
            check_val($sformatf("y_u[%0d] after write", i), got_u[i], prev_u[i]);
            check_val($sformatf("y_v[%0d] after write", i), got_v[i], prev_v[i]);
        end
        check_val("y_v[6] after write", got_v[6], prev_v[6]); // v is 0 on the diagonal
        check_true(got_u[6] !== prev_u[6], "y_u[6] did not change after the sample write");

        $display("errors: value %0d, other %0d", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((n_runs * run_limit + rst_cyc) * clk_period);
        $display("watchdog expired before all runs finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: tb/tri_testdata.hex
// one case per line: x[0] .. x[15] (8 bit), then expected y_u(15) and y_v(15) (32 bit)
// all values hex
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00000000 00000000
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 00021de0 0001de20
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 00000220 000001e0
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00000040 0000003c
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff 000003fc 00000000
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 00000aa0 000008c0
10 0f 0e 0d 0c 0b 0a 09 08 07 06 05 04 03 02 01 00001760 00001540
